/* source/surf_pkg.sv */
package surf_pkg;

	// Firmware version fields.
	localparam logic [3:0] BOARDREV = 4'd1;
	localparam logic [3:0] MONTH    = 4'd8;
	localparam logic [7:0] DAY      = 8'd29;
	localparam logic [3:0] MAJOR    = 4'd0;
	localparam logic [3:0] MINOR    = 4'd6;
	localparam logic [7:0] REVISION = 8'd1;

	// Packed version word, reads as 0x181D0601.
	localparam logic [31:0] VERSION = {BOARDREV, MONTH, DAY, MAJOR, MINOR, REVISION};

	// Timing monitor lines from the LAB4s.
	localparam int MONTIMING_WIDTH = 12;
	// Lines whose differential pair is swapped on the board.
	localparam logic [MONTIMING_WIDTH-1:0] MONTIMING_POLARITY = 12'b1000_0000_0000;

	// Board LEDs.
	localparam int LED_WIDTH = 4;

	// Bit positions inside CONTROL.
	localparam int CTRL_CLK_SEL_BIT = 0;
	localparam int CTRL_OSC_DIS_BIT = 1;
	localparam int CTRL_LED_LSB     = 4;

	// ID/control region offsets.
	localparam logic [11:0] REG_VERSION = 12'h000;
	localparam logic [11:0] REG_SCRATCH = 12'h004;
	localparam logic [11:0] REG_CONTROL = 12'h008;

	// Timing region offsets.
	localparam logic [11:0] REG_MONTIMING  = 12'h000;
	localparam logic [11:0] REG_DIV4_COUNT = 12'h004;

endpackage

/* source/bus_pkg.sv */
package bus_pkg;

	// AXI4-Lite widths.
	localparam int ADDR_WIDTH = 16;
	localparam int DATA_WIDTH = 32;
	localparam int STRB_WIDTH = 4;

	// Low address bits are the offset within a region.
	localparam int OFFSET_WIDTH = 12;
	// Remaining top bits select the region.
	localparam int REGION_WIDTH = ADDR_WIDTH - OFFSET_WIDTH;

	// Response codes as on the AXI wires.
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		EXOKAY = 2'b01,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} axi_resp_e;

	// Register regions, anything else is unmapped.
	typedef enum logic [REGION_WIDTH-1:0] {
		REGION_ID_CTRL = 4'd0,
		REGION_TIMING  = 4'd1
	} region_e;

endpackage

/* source/axil_slave_port.sv */
`timescale 1ns/10ps

module axil_slave_port import bus_pkg::*; (
	input  logic                  sys_clk,
	input  logic                  arst_n_i,
	// Write address and data.
	input  logic                  s_awvalid_i,
	output logic                  s_awready_o,
	input  logic [ADDR_WIDTH-1:0] s_awaddr_i,
	input  logic                  s_wvalid_i,
	output logic                  s_wready_o,
	input  logic [DATA_WIDTH-1:0] s_wdata_i,
	input  logic [STRB_WIDTH-1:0] s_wstrb_i,
	// Write response.
	output logic                  s_bvalid_o,
	input  logic                  s_bready_i,
	output axi_resp_e             s_bresp_o,
	// Read address.
	input  logic                  s_arvalid_i,
	output logic                  s_arready_o,
	input  logic [ADDR_WIDTH-1:0] s_araddr_i,
	// Read data.
	output logic                  s_rvalid_o,
	input  logic                  s_rready_i,
	output logic [DATA_WIDTH-1:0] s_rdata_o,
	output axi_resp_e             s_rresp_o,
	// Internal request toward the decoder.
	output logic                  req_valid_o,
	output logic                  req_write_o,
	output logic [ADDR_WIDTH-1:0] req_addr_o,
	output logic [DATA_WIDTH-1:0] req_wdata_o,
	output logic [STRB_WIDTH-1:0] req_wstrb_o,
	input  logic [DATA_WIDTH-1:0] rsp_rdata_i,
	input  axi_resp_e             rsp_resp_i
);

	logic busy;
	logic wr_accept;
	logic rd_accept;

	logic                  bvalid_q;
	axi_resp_e             bresp_q;
	logic                  rvalid_q;
	logic [DATA_WIDTH-1:0] rdata_q;
	axi_resp_e             rresp_q;

	// One transaction in flight, a held response blocks both channels.
	assign busy = bvalid_q | rvalid_q;

	// Writes need address and data together and win over reads.
	assign wr_accept = !busy && s_awvalid_i && s_wvalid_i;
	assign rd_accept = !busy && s_arvalid_i && !wr_accept;

	// AW and W are taken in the same cycle.
	assign s_awready_o = wr_accept;
	assign s_wready_o  = wr_accept;
	assign s_arready_o = rd_accept;

	// Request is a single strobe on the acceptance cycle.
	assign req_valid_o = wr_accept | rd_accept;
	assign req_write_o = wr_accept;
	assign req_addr_o  = wr_accept ? s_awaddr_i : s_araddr_i;
	assign req_wdata_o = s_wdata_i;
	assign req_wstrb_o = s_wstrb_i;

	// Response valids.
	always_ff @(posedge sys_clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			bvalid_q <= 1'b0;
			rvalid_q <= 1'b0;
		end else begin
			if (wr_accept)
				bvalid_q <= 1'b1;
			else if (s_bready_i)
				bvalid_q <= 1'b0;
			if (rd_accept)
				rvalid_q <= 1'b1;
			else if (s_rready_i)
				rvalid_q <= 1'b0;
		end
	end

	// Response payload, captured once and held until taken.
	always_ff @(posedge sys_clk) begin
		if (wr_accept)
			bresp_q <= rsp_resp_i;
		if (rd_accept) begin
			rdata_q <= rsp_rdata_i;
			rresp_q <= rsp_resp_i;
		end
	end

	assign s_bvalid_o = bvalid_q;
	assign s_bresp_o  = bresp_q;
	assign s_rvalid_o = rvalid_q;
	assign s_rdata_o  = rdata_q;
	assign s_rresp_o  = rresp_q;

endmodule

/* source/ctrl_decode.sv */
`timescale 1ns/10ps

module ctrl_decode import bus_pkg::*; (
	// Request from the slave port.
	input  logic                    req_valid_i,
	input  logic                    req_write_i,
	input  logic [ADDR_WIDTH-1:0]   req_addr_i,
	input  logic [DATA_WIDTH-1:0]   req_wdata_i,
	input  logic [STRB_WIDTH-1:0]   req_wstrb_i,
	// Returns from the register blocks.
	input  logic [DATA_WIDTH-1:0]   id_rdata_i,
	input  logic                    id_err_i,
	input  logic [DATA_WIDTH-1:0]   tm_rdata_i,
	input  logic                    tm_err_i,
	// Shared block request.
	output logic                    id_sel_o,
	output logic                    tm_sel_o,
	output logic [OFFSET_WIDTH-1:0] blk_offset_o,
	output logic                    blk_write_o,
	output logic [DATA_WIDTH-1:0]   blk_wdata_o,
	output logic [STRB_WIDTH-1:0]   blk_wstrb_o,
	// Response back to the slave port.
	output logic [DATA_WIDTH-1:0]   rsp_rdata_o,
	output axi_resp_e               rsp_resp_o
);

	region_e region;

	// Top address bits name the region.
	assign region = region_e'(req_addr_i[ADDR_WIDTH-1 -: REGION_WIDTH]);

	// At most one block sees a strobe.
	assign id_sel_o = req_valid_i && (region == REGION_ID_CTRL);
	assign tm_sel_o = req_valid_i && (region == REGION_TIMING);

	// Blocks share offset, direction and write payload.
	assign blk_offset_o = req_addr_i[OFFSET_WIDTH-1:0];
	assign blk_write_o  = req_write_i;
	assign blk_wdata_o  = req_wdata_i;
	assign blk_wstrb_o  = req_wstrb_i;

	// Read data and response, answered in the request cycle.
	always_comb begin
		case (region)
			REGION_ID_CTRL: begin
				rsp_rdata_o = id_rdata_i;
				rsp_resp_o  = id_err_i ? SLVERR : OKAY;
			end
			REGION_TIMING: begin
				rsp_rdata_o = tm_rdata_i;
				rsp_resp_o  = tm_err_i ? SLVERR : OKAY;
			end
			default: begin
				// Unmapped space reads as zero.
				rsp_rdata_o = '0;
				rsp_resp_o  = DECERR;
			end
		endcase
	end

endmodule

/* source/id_ctrl_regs.sv */
`timescale 1ns/10ps

module id_ctrl_regs import bus_pkg::*, surf_pkg::*; (
	input  logic                    sys_clk,
	input  logic                    arst_n_i,
	// Register access.
	input  logic                    sel_i,
	input  logic [OFFSET_WIDTH-1:0] offset_i,
	input  logic                    write_i,
	input  logic [DATA_WIDTH-1:0]   wdata_i,
	input  logic [STRB_WIDTH-1:0]   wstrb_i,
	output logic [DATA_WIDTH-1:0]   rdata_o,
	output logic                    err_o,
	// Board controls.
	output logic                    clk_sel_o,
	output logic                    local_osc_en_o,
	output logic [LED_WIDTH-1:0]    led_o
);

	logic [DATA_WIDTH-1:0] scratch_q;
	logic [DATA_WIDTH-1:0] control_q;
	logic                  scratch_we;
	logic                  control_we;

	assign scratch_we = sel_i && write_i && (offset_i == REG_SCRATCH);
	assign control_we = sel_i && write_i && (offset_i == REG_CONTROL);

	// Byte-lane writes to SCRATCH and CONTROL.
	always_ff @(posedge sys_clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			scratch_q <= '0;
			control_q <= '0;
		end else begin
			for (int b = 0; b < STRB_WIDTH; b++) begin
				if (scratch_we && wstrb_i[b])
					scratch_q[8*b +: 8] <= wdata_i[8*b +: 8];
				if (control_we && wstrb_i[b])
					control_q[8*b +: 8] <= wdata_i[8*b +: 8];
			end
		end
	end

	// Read mux, writes to VERSION fall through harmlessly.
	always_comb begin
		err_o = 1'b0;
		case (offset_i)
			REG_VERSION: rdata_o = VERSION;
			REG_SCRATCH: rdata_o = scratch_q;
			REG_CONTROL: rdata_o = control_q;
			default: begin
				rdata_o = '0;
				err_o   = 1'b1;
			end
		endcase
	end

	// Clock select goes out as a plain level.
	assign clk_sel_o = control_q[CTRL_CLK_SEL_BIT];
	// Oscillator enable is active high, the bit is a disable.
	assign local_osc_en_o = ~control_q[CTRL_OSC_DIS_BIT];
	assign led_o = control_q[CTRL_LED_LSB +: LED_WIDTH];

endmodule

/* source/timing_monitor.sv */
`timescale 1ns/10ps

module timing_monitor import bus_pkg::*, surf_pkg::*; (
	input  logic                       sys_clk,
	input  logic                       arst_n_i,
	// Register access.
	input  logic                       sel_i,
	input  logic [OFFSET_WIDTH-1:0]    offset_i,
	input  logic                       write_i,
	output logic [DATA_WIDTH-1:0]      rdata_o,
	output logic                       err_o,
	// Timing inputs.
	input  logic [MONTIMING_WIDTH-1:0] montiming_i,
	input  logic                       div4_flag_i,
	// Internal SST copy for MON2.
	output logic                       sst_copy_o
);

	logic [MONTIMING_WIDTH-1:0] montiming_q;
	logic [DATA_WIDTH-1:0]      div4_count_q;
	logic                       count_clr;
	logic [1:0]                 div4_dly_q;
	logic                       sst_copy_q;

	// Polarity corrected sample of the timing lines.
	always_ff @(posedge sys_clk) begin
		montiming_q <= montiming_i ^ MONTIMING_POLARITY;
	end

	assign count_clr = sel_i && write_i && (offset_i == REG_DIV4_COUNT);

	// Flag counter, a write of any value clears it.
	always_ff @(posedge sys_clk or negedge arst_n_i) begin
		if (!arst_n_i)
			div4_count_q <= '0;
		else if (count_clr)
			div4_count_q <= '0;
		else if (div4_flag_i)
			div4_count_q <= div4_count_q + 1'b1;
	end

	// Set on the flag, cleared two cycles later.
	// High two cycles of every four with a regular flag.
	always_ff @(posedge sys_clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			div4_dly_q <= '0;
			sst_copy_q <= 1'b0;
		end else begin
			div4_dly_q <= {div4_dly_q[0], div4_flag_i};
			if (div4_flag_i)
				sst_copy_q <= 1'b1;
			else if (div4_dly_q[1])
				sst_copy_q <= 1'b0;
		end
	end

	assign sst_copy_o = sst_copy_q;

	// Read mux, MONTIMING is read-only.
	always_comb begin
		rdata_o = '0;
		err_o   = 1'b0;
		case (offset_i)
			REG_MONTIMING: begin
				rdata_o[MONTIMING_WIDTH-1:0] = montiming_q;
				err_o = write_i;
			end
			REG_DIV4_COUNT: rdata_o = div4_count_q;
			default: err_o = 1'b1;
		endcase
	end

endmodule

/* source/surf_ctrl_top.sv */
`timescale 1ns/10ps

module surf_ctrl_top import bus_pkg::*, surf_pkg::*; (
	input  logic                       sys_clk,
	input  logic                       arst_n_i,
	// AXI4-Lite slave.
	input  logic                       s_awvalid_i,
	output logic                       s_awready_o,
	input  logic [ADDR_WIDTH-1:0]      s_awaddr_i,
	input  logic                       s_wvalid_i,
	output logic                       s_wready_o,
	input  logic [DATA_WIDTH-1:0]      s_wdata_i,
	input  logic [STRB_WIDTH-1:0]      s_wstrb_i,
	output logic                       s_bvalid_o,
	input  logic                       s_bready_i,
	output axi_resp_e                  s_bresp_o,
	input  logic                       s_arvalid_i,
	output logic                       s_arready_o,
	input  logic [ADDR_WIDTH-1:0]      s_araddr_i,
	output logic                       s_rvalid_o,
	input  logic                       s_rready_i,
	output logic [DATA_WIDTH-1:0]      s_rdata_o,
	output axi_resp_e                  s_rresp_o,
	// Timing inputs.
	input  logic [MONTIMING_WIDTH-1:0] montiming_i,
	input  logic                       div4_flag_i,
	// Board outputs.
	output logic                       clk_sel_o,
	output logic                       local_osc_en_o,
	output logic [LED_WIDTH-1:0]       led_o,
	output logic                       sst_copy_o
);

	// Request path.
	logic                    req_valid;
	logic                    req_write;
	logic [ADDR_WIDTH-1:0]   req_addr;
	logic [DATA_WIDTH-1:0]   req_wdata;
	logic [STRB_WIDTH-1:0]   req_wstrb;
	logic [DATA_WIDTH-1:0]   rsp_rdata;
	axi_resp_e               rsp_resp;
	// Block side.
	logic                    id_sel;
	logic                    tm_sel;
	logic [OFFSET_WIDTH-1:0] blk_offset;
	logic                    blk_write;
	logic [DATA_WIDTH-1:0]   blk_wdata;
	logic [STRB_WIDTH-1:0]   blk_wstrb;
	logic [DATA_WIDTH-1:0]   id_rdata;
	logic                    id_err;
	logic [DATA_WIDTH-1:0]   tm_rdata;
	logic                    tm_err;

	axil_slave_port u_axil_slave_port (
		.sys_clk     (sys_clk),
		.arst_n_i    (arst_n_i),
		.s_awvalid_i (s_awvalid_i),
		.s_awready_o (s_awready_o),
		.s_awaddr_i  (s_awaddr_i),
		.s_wvalid_i  (s_wvalid_i),
		.s_wready_o  (s_wready_o),
		.s_wdata_i   (s_wdata_i),
		.s_wstrb_i   (s_wstrb_i),
		.s_bvalid_o  (s_bvalid_o),
		.s_bready_i  (s_bready_i),
		.s_bresp_o   (s_bresp_o),
		.s_arvalid_i (s_arvalid_i),
		.s_arready_o (s_arready_o),
		.s_araddr_i  (s_araddr_i),
		.s_rvalid_o  (s_rvalid_o),
		.s_rready_i  (s_rready_i),
		.s_rdata_o   (s_rdata_o),
		.s_rresp_o   (s_rresp_o),
		.req_valid_o (req_valid),
		.req_write_o (req_write),
		.req_addr_o  (req_addr),
		.req_wdata_o (req_wdata),
		.req_wstrb_o (req_wstrb),
		.rsp_rdata_i (rsp_rdata),
		.rsp_resp_i  (rsp_resp)
	);

	ctrl_decode u_ctrl_decode (
		.req_valid_i  (req_valid),
		.req_write_i  (req_write),
		.req_addr_i   (req_addr),
		.req_wdata_i  (req_wdata),
		.req_wstrb_i  (req_wstrb),
		.id_rdata_i   (id_rdata),
		.id_err_i     (id_err),
		.tm_rdata_i   (tm_rdata),
		.tm_err_i     (tm_err),
		.id_sel_o     (id_sel),
		.tm_sel_o     (tm_sel),
		.blk_offset_o (blk_offset),
		.blk_write_o  (blk_write),
		.blk_wdata_o  (blk_wdata),
		.blk_wstrb_o  (blk_wstrb),
		.rsp_rdata_o  (rsp_rdata),
		.rsp_resp_o   (rsp_resp)
	);

	id_ctrl_regs u_id_ctrl_regs (
		.sys_clk        (sys_clk),
		.arst_n_i       (arst_n_i),
		.sel_i          (id_sel),
		.offset_i       (blk_offset),
		.write_i        (blk_write),
		.wdata_i        (blk_wdata),
		.wstrb_i        (blk_wstrb),
		.rdata_o        (id_rdata),
		.err_o          (id_err),
		.clk_sel_o      (clk_sel_o),
		.local_osc_en_o (local_osc_en_o),
		.led_o          (led_o)
	);

	timing_monitor u_timing_monitor (
		.sys_clk     (sys_clk),
		.arst_n_i    (arst_n_i),
		.sel_i       (tm_sel),
		.offset_i    (blk_offset),
		.write_i     (blk_write),
		.rdata_o     (tm_rdata),
		.err_o       (tm_err),
		.montiming_i (montiming_i),
		.div4_flag_i (div4_flag_i),
		.sst_copy_o  (sst_copy_o)
	);

endmodule

/* tests/surf_ctrl_assertions.sv */
`timescale 1ns/10ps

module surf_ctrl_assertions import bus_pkg::*, surf_pkg::*; (
	input logic                 sys_clk,
	input logic                 arst_n_i,
	input logic                 s_awready_o,
	input logic                 s_wready_o,
	input logic                 s_arready_o,
	input logic                 s_bvalid_o,
	input logic                 s_bready_i,
	input logic [1:0]           s_bresp_o,
	input logic                 s_rvalid_o,
	input logic                 s_rready_i,
	input logic [DATA_WIDTH-1:0] s_rdata_o,
	input logic [1:0]           s_rresp_o,
	input logic                 div4_flag_i,
	input logic                 clk_sel_o,
	input logic                 local_osc_en_o,
	input logic [LED_WIDTH-1:0] led_o,
	input logic                 sst_copy_o
);

	int unsigned violations = 0;

	// Held responses keep their payload until taken.
	b_hold: assert property (@(posedge sys_clk) disable iff (!arst_n_i)
		s_bvalid_o && !s_bready_i |=> s_bvalid_o && $stable(s_bresp_o))
	else begin
		violations++;
		$error("Write response dropped or changed before bready");
	end
	r_hold: assert property (@(posedge sys_clk) disable iff (!arst_n_i)
		s_rvalid_o && !s_rready_i |=> s_rvalid_o && $stable(s_rdata_o) && $stable(s_rresp_o))
	else begin
		violations++;
		$error("Read response dropped or changed before rready");
	end
	// Responses follow acceptance by one cycle.
	resp_next: assert property (@(posedge sys_clk) disable iff (!arst_n_i)
		(s_awready_o |=> s_bvalid_o) and (s_arready_o |=> s_rvalid_o))
	else begin
		violations++;
		$error("Response valid did not rise the cycle after acceptance");
	end

	// AW and W go together.
	aw_w_pair: assert property (@(posedge sys_clk) disable iff (!arst_n_i)
		s_awready_o == s_wready_o)
	else begin
		violations++;
		$error("awready and wready differ");
	end

	// One transaction at a time.
	no_overlap: assert property (@(posedge sys_clk) disable iff (!arst_n_i)
		(s_bvalid_o || s_rvalid_o) |-> !s_awready_o && !s_arready_o)
	else begin
		violations++;
		$error("New request accepted while a response is pending");
	end

	// Reset state, seen on the first edge after release.
	reset_state: assert property (@(posedge sys_clk)
		$rose(arst_n_i) |-> !s_awready_o && !s_wready_o && !s_arready_o && !s_bvalid_o
			&& !s_rvalid_o && !clk_sel_o && local_osc_en_o && led_o == '0 && !sst_copy_o)
	else begin
		violations++;
		$error("Outputs not in reset state after reset");
	end
	// Board pins only move right after a write handshake.
	pins_on_write: assert property (@(posedge sys_clk) disable iff (!arst_n_i)
		!$stable({clk_sel_o, local_osc_en_o, led_o}) |-> $past(s_awready_o))
	else begin
		violations++;
		$error("Board outputs changed without a write");
	end

	// SST copy rises after a flag and falls three cycles after it.
	sst_rise: assert property (@(posedge sys_clk) disable iff (!arst_n_i)
		div4_flag_i |=> sst_copy_o)
	else begin
		violations++;
		$error("SST copy did not rise after the flag");
	end
	sst_fall: assert property (@(posedge sys_clk) disable iff (!arst_n_i)
		div4_flag_i ##2 !div4_flag_i |=> !sst_copy_o)
	else begin
		violations++;
		$error("SST copy did not fall three cycles after the flag");
	end
	sst_cause: assert property (@(posedge sys_clk) disable iff (!arst_n_i)
		$rose(sst_copy_o) |-> $past(div4_flag_i))
	else begin
		violations++;
		$error("SST copy rose without a flag");
	end

endmodule

bind surf_ctrl_top surf_ctrl_assertions u_assertions (.*);

/* tests/tb_surf_ctrl.sv */
`timescale 1ns/10ps

module tb_surf_ctrl import bus_pkg::*, surf_pkg::*; ();

	localparam int CLK_PERIOD      = 8;
	localparam int DRIVE_DELAY     = 1;
	localparam int RESET_CYCLES    = 10;
	localparam int MAX_READY_DELAY = 5;
	localparam int FLAG_CYCLES     = 80;
	// Version 3, scratch 16, overlap 4, control 13, montiming 5, flag counter 4, errors 6.
	localparam int NUM_TRANS       = 51;
	// Worst case per transaction is acceptance, ready delay and transfer.
	localparam int WATCHDOG_NS =
		(NUM_TRANS * (MAX_READY_DELAY + 4) + FLAG_CYCLES + RESET_CYCLES + 200) * CLK_PERIOD;

	// Region codes in the top address nibble.
	localparam logic [3:0] ID_REGION = 4'h0;
	localparam logic [3:0] TM_REGION = 4'h1;

	logic                       sys_clk;
	logic                       arst_n_i;
	logic                       s_awvalid_i;
	logic                       s_awready_o;
	logic [ADDR_WIDTH-1:0]      s_awaddr_i;
	logic                       s_wvalid_i;
	logic                       s_wready_o;
	logic [DATA_WIDTH-1:0]      s_wdata_i;
	logic [STRB_WIDTH-1:0]      s_wstrb_i;
	logic                       s_bvalid_o;
	logic                       s_bready_i;
	axi_resp_e                  s_bresp_o;
	logic                       s_arvalid_i;
	logic                       s_arready_o;
	logic [ADDR_WIDTH-1:0]      s_araddr_i;
	logic                       s_rvalid_o;
	logic                       s_rready_i;
	logic [DATA_WIDTH-1:0]      s_rdata_o;
	axi_resp_e                  s_rresp_o;
	logic [MONTIMING_WIDTH-1:0] montiming_i;
	logic                       div4_flag_i;
	logic                       clk_sel_o;
	logic                       local_osc_en_o;
	logic [LED_WIDTH-1:0]       led_o;
	logic                       sst_copy_o;

	logic [31:0] rng_state = 32'h336f_2a4f;
	int          check_errors = 0;

	surf_ctrl_top i_dut (.*);

	initial begin
		sys_clk = 1'b0;
		forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
	end

	// Linear congruential generator.
	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	// Byte lanes with a strobe take the new value.
	function automatic logic [31:0] merge_bytes(input logic [31:0] old_val,
			input logic [31:0] new_val, input logic [3:0] strb);
		logic [31:0] result;
		result = old_val;
		for (int b = 0; b < 4; b++) begin
			if (strb[b])
				result[8*b +: 8] = new_val[8*b +: 8];
		end
		return result;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp)
		else begin
			$display("MISMATCH %s: got 0x%08h, expected 0x%08h", name, got, exp);
			check_errors++;
		end
	endtask

	// Moves to the drive point of the next cycle.
	task automatic next_cycle();
		@(posedge sys_clk);
		#DRIVE_DELAY;
	endtask

	task automatic axi_write(input logic [15:0] addr, input logic [31:0] data,
			input logic [3:0] strb, output axi_resp_e resp);
		logic [31:0] r;
		s_awvalid_i = 1'b1;
		s_awaddr_i  = addr;
		s_wvalid_i  = 1'b1;
		s_wdata_i   = data;
		s_wstrb_i   = strb;
		// Ready is sampled mid-cycle, the transfer happens on the next edge.
		do
			@(negedge sys_clk);
		while (!s_awready_o);
		next_cycle();
		s_awvalid_i = 1'b0;
		s_wvalid_i  = 1'b0;
		// Random back-pressure on B.
		r = next_rand();
		repeat (r[31:24] % (MAX_READY_DELAY + 1))
			next_cycle();
		s_bready_i = 1'b1;
		do
			@(negedge sys_clk);
		while (!s_bvalid_o);
		resp = s_bresp_o;
		next_cycle();
		s_bready_i = 1'b0;
	endtask

	task automatic axi_read(input logic [15:0] addr, output logic [31:0] data,
			output axi_resp_e resp);
		logic [31:0] r;
		s_arvalid_i = 1'b1;
		s_araddr_i  = addr;
		do
			@(negedge sys_clk);
		while (!s_arready_o);
		next_cycle();
		s_arvalid_i = 1'b0;
		// Random back-pressure on R.
		r = next_rand();
		repeat (r[31:24] % (MAX_READY_DELAY + 1))
			next_cycle();
		s_rready_i = 1'b1;
		do
			@(negedge sys_clk);
		while (!s_rvalid_o);
		data = s_rdata_o;
		resp = s_rresp_o;
		next_cycle();
		s_rready_i = 1'b0;
	endtask

	task automatic write_expect(input logic [15:0] addr, input logic [31:0] data,
			input logic [3:0] strb, input axi_resp_e exp_resp);
		axi_resp_e resp;
		axi_write(addr, data, strb, resp);
		check_value("s_bresp_o", resp, exp_resp);
	endtask

	task automatic read_expect(input logic [15:0] addr, input logic [31:0] exp_data,
			input axi_resp_e exp_resp, input bit check_data);
		logic [31:0] data;
		axi_resp_e   resp;
		axi_read(addr, data, resp);
		check_value("s_rresp_o", resp, exp_resp);
		if (check_data)
			check_value("s_rdata_o", data, exp_data);
	endtask

	// Write and read offered together against held responses.
	// The write wins, AR waits behind B, then AW waits for W.
	task automatic contend_write_read(input logic [15:0] addr, input logic [31:0] data);
		s_awvalid_i = 1'b1;
		s_awaddr_i  = addr;
		s_wvalid_i  = 1'b1;
		s_wdata_i   = data;
		s_wstrb_i   = 4'hF;
		s_arvalid_i = 1'b1;
		s_araddr_i  = addr;
		do
			@(negedge sys_clk);
		while (!s_awready_o);
		next_cycle();
		s_awvalid_i = 1'b0;
		s_wvalid_i  = 1'b0;
		// AR stays up while B is held.
		repeat (MAX_READY_DELAY)
			next_cycle();
		s_bready_i = 1'b1;
		do
			@(negedge sys_clk);
		while (!s_bvalid_o);
		check_value("s_bresp_o", s_bresp_o, OKAY);
		next_cycle();
		s_bready_i = 1'b0;
		do
			@(negedge sys_clk);
		while (!s_arready_o);
		next_cycle();
		s_arvalid_i = 1'b0;
		// AW alone while R is held.
		s_awvalid_i = 1'b1;
		s_wdata_i   = ~data;
		repeat (MAX_READY_DELAY)
			next_cycle();
		s_rready_i = 1'b1;
		do
			@(negedge sys_clk);
		while (!s_rvalid_o);
		check_value("s_rresp_o", s_rresp_o, OKAY);
		check_value("s_rdata_o", s_rdata_o, data);
		next_cycle();
		s_rready_i = 1'b0;
		// Port is idle now, AW still waits for W.
		repeat (2) begin
			@(negedge sys_clk);
			check_value("s_awready_o", s_awready_o, 1'b0);
		end
		next_cycle();
		s_wvalid_i = 1'b1;
		do
			@(negedge sys_clk);
		while (!s_awready_o);
		next_cycle();
		s_awvalid_i = 1'b0;
		s_wvalid_i  = 1'b0;
		s_bready_i  = 1'b1;
		do
			@(negedge sys_clk);
		while (!s_bvalid_o);
		check_value("s_bresp_o", s_bresp_o, OKAY);
		next_cycle();
		s_bready_i = 1'b0;
	endtask

	// Regular mode flags every fourth cycle, otherwise at random.
	task automatic drive_flags(input int cycles, input bit regular, output int count);
		logic [31:0] r;
		count = 0;
		for (int i = 0; i < cycles; i++) begin
			r = next_rand();
			div4_flag_i = regular ? (i % 4 == 0) : r[29];
			if (div4_flag_i)
				count++;
			next_cycle();
		end
		div4_flag_i = 1'b0;
	endtask

	// Stops at the first failed check or bound assertion.
	initial begin
		wait (check_errors != 0 || i_dut.u_assertions.violations != 0);
		$display("Test failures found");
		$fatal(1, "Stopped at the first error");
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the register tests did not finish in time");
		$display("Test failures found");
		$fatal(1, "Watchdog expired");
	end

	initial begin
		logic [31:0] data;
		logic [31:0] r;
		logic [3:0]  strb;
		logic [3:0]  region;
		logic [31:0] scratch_model;
		logic [31:0] control_model;
		int          n_regular;
		int          n_irregular;
		arst_n_i    = 1'b0;
		s_awvalid_i = 1'b0;
		s_awaddr_i  = '0;
		s_wvalid_i  = 1'b0;
		s_wdata_i   = '0;
		s_wstrb_i   = '0;
		s_bready_i  = 1'b0;
		s_arvalid_i = 1'b0;
		s_araddr_i  = '0;
		s_rready_i  = 1'b0;
		montiming_i = '0;
		div4_flag_i = 1'b0;
		repeat (RESET_CYCLES)
			@(posedge sys_clk);
		#DRIVE_DELAY;
		arst_n_i = 1'b1;
		next_cycle();

		// VERSION is fixed and ignores writes.
		read_expect({ID_REGION, REG_VERSION}, 32'h181D_0601, OKAY, 1'b1);
		write_expect({ID_REGION, REG_VERSION}, next_rand(), 4'hF, OKAY);
		read_expect({ID_REGION, REG_VERSION}, 32'h181D_0601, OKAY, 1'b1);

		// SCRATCH with random byte strobes.
		scratch_model = '0;
		repeat (8) begin
			data = next_rand();
			r    = next_rand();
			strb = r[27:24];
			write_expect({ID_REGION, REG_SCRATCH}, data, strb, OKAY);
			scratch_model = merge_bytes(scratch_model, data, strb);
			read_expect({ID_REGION, REG_SCRATCH}, scratch_model, OKAY, 1'b1);
		end

		// Overlapping requests on SCRATCH.
		data = next_rand();
		contend_write_read({ID_REGION, REG_SCRATCH}, data);
		read_expect({ID_REGION, REG_SCRATCH}, ~data, OKAY, 1'b1);

		// CONTROL drives the board pins, byte 0 always written.
		read_expect({ID_REGION, REG_CONTROL}, 32'h0, OKAY, 1'b1);
		control_model = '0;
		repeat (6) begin
			data = next_rand();
			r    = next_rand();
			strb = r[27:24] | 4'h1;
			write_expect({ID_REGION, REG_CONTROL}, data, strb, OKAY);
			control_model = merge_bytes(control_model, data, strb);
			check_value("clk_sel_o", clk_sel_o, control_model[CTRL_CLK_SEL_BIT]);
			check_value("local_osc_en_o", local_osc_en_o, !control_model[CTRL_OSC_DIS_BIT]);
			check_value("led_o", led_o, control_model[CTRL_LED_LSB +: LED_WIDTH]);
			read_expect({ID_REGION, REG_CONTROL}, control_model, OKAY, 1'b1);
		end

		// MONTIMING with the inverted line 11.
		repeat (4) begin
			r = next_rand();
			montiming_i = r[31:20];
			next_cycle();
			read_expect({TM_REGION, REG_MONTIMING}, {20'd0, r[31:20] ^ 12'h800}, OKAY, 1'b1);
		end
		write_expect({TM_REGION, REG_MONTIMING}, next_rand(), 4'hF, SLVERR);

		// Flag counter, regular then irregular flags.
		write_expect({TM_REGION, REG_DIV4_COUNT}, next_rand(), 4'hF, OKAY);
		drive_flags(FLAG_CYCLES / 2, 1'b1, n_regular);
		drive_flags(FLAG_CYCLES / 2, 1'b0, n_irregular);
		read_expect({TM_REGION, REG_DIV4_COUNT}, n_regular + n_irregular, OKAY, 1'b1);
		write_expect({TM_REGION, REG_DIV4_COUNT}, 32'h0, 4'h0, OKAY);
		read_expect({TM_REGION, REG_DIV4_COUNT}, 32'h0, OKAY, 1'b1);

		// Unmapped regions and unknown offsets.
		read_expect(16'h2000, 32'h0, DECERR, 1'b1);
		r = next_rand();
		region = 4'd2 + (r[31:28] % 4'd14);
		read_expect({region, r[11:0]}, 32'h0, DECERR, 1'b1);
		write_expect({region, r[11:0]}, next_rand(), 4'hF, DECERR);
		read_expect({ID_REGION, 12'h00C}, 32'h0, SLVERR, 1'b0);
		write_expect({ID_REGION, 12'h010}, next_rand(), 4'hF, SLVERR);
		read_expect({TM_REGION, 12'h008}, 32'h0, SLVERR, 1'b0);

		repeat (4)
			next_cycle();
		if (check_errors == 0 && i_dut.u_assertions.violations == 0) begin
			$display("All tests passed!");
			$finish;
		end else begin
			$display("Test failures found");
			$fatal(1, "Checks failed");
		end
	end

endmodule

/* list.f */
source/surf_pkg.sv
source/bus_pkg.sv
source/axil_slave_port.sv
source/ctrl_decode.sv
source/id_ctrl_regs.sv
source/timing_monitor.sv
source/surf_ctrl_top.sv
tests/surf_ctrl_assertions.sv
tests/tb_surf_ctrl.sv

/* Bender.yml */
package:
  name: surf_ctrl

sources:
  - source/surf_pkg.sv
  - source/bus_pkg.sv
  - source/axil_slave_port.sv
  - source/ctrl_decode.sv
  - source/id_ctrl_regs.sv
  - source/timing_monitor.sv
  - source/surf_ctrl_top.sv
  - target: test
    files:
      - tests/surf_ctrl_assertions.sv
      - tests/tb_surf_ctrl.sv
